// ==== pif_frame_pkg.sv ====
// ==========================================================
// PIF frame package
// Bus, word and write-FIFO entry formats of the PIF bridge
// ==========================================================
package pif_frame_pkg;

  // Bus and word geometry
  localparam int BYTE_W     = 8;
  localparam int ADDR_W     = 8;
  localparam int WORD_BYTES = 4;
  localparam int WORD_W     = WORD_BYTES * BYTE_W;

  // Write-FIFO entry is address above word
  localparam int WFF_W = ADDR_W + WORD_W;

  // Address byte decode
  localparam int ADDR_DATA_BIT = 7;           // Set when data bytes follow
  localparam logic [ADDR_W-1:0] ADDR_HOLD = 8'hA0; // Burst address that never advances

  typedef logic [BYTE_W-1:0] pif_byte_t;
  typedef logic [WORD_W-1:0] pif_word_t;
  typedef logic [WFF_W-1:0]  wff_entry_t;

endpackage

// ==== pif_fsm_pkg.sv ====
// ==========================================================
// PIF sequencer package
// State encodings of the write and read sequencers
// ==========================================================
package pif_fsm_pkg;

  // Write sequencer
  typedef enum logic [2:0] {
    WR_IDLE      = 3'd0,
    WR_ADDR      = 3'd1,  // Waiting for address byte
    WR_ADDR_ONLY = 3'd2,  // Data bit of the captured address decides
    WR_DATA0     = 3'd3,
    WR_DATA1     = 3'd4,
    WR_DATA2     = 3'd5,
    WR_DATA3     = 3'd6,
    WR_BURST     = 3'd7   // One cycle window for a back-to-back word
  } wr_state_t;

  // Read sequencer
  typedef enum logic [2:0] {
    RD_IDLE      = 3'd0,
    RD_WAIT_WORD = 3'd1,  // Byte 0 goes out here
    RD_BYTE1     = 3'd2,
    RD_BYTE2     = 3'd3,
    RD_BYTE3     = 3'd4
  } rd_state_t;

  // Byte position inside a configuration word
  typedef logic [1:0] byte_lane_t;

endpackage

// ==== pif_frame_regs.sv ====
// ==========================================================
// PIF frame registers
// Address and data byte storage, write-FIFO entry build
// ==========================================================
module pif_frame_regs (
  input  logic                      fcb_sys_clk,
  input  logic                      fcb_sys_rst_n,
  input  pif_frame_pkg::pif_byte_t  pif_di,
  input  logic                      addr_load,
  input  logic                      byte_load,
  input  pif_fsm_pkg::byte_lane_t   byte_lane,
  input  logic                      addr_step,
  output pif_frame_pkg::pif_byte_t  addr_q,
  output pif_frame_pkg::wff_entry_t wff_entry
);
  import pif_frame_pkg::*;

  // Stored data bytes 0 to 2
  pif_byte_t byte_q [WORD_BYTES-1];

  // Register address with burst auto-increment
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      addr_q <= '0;
    end else if (addr_step) begin
      if (addr_q != ADDR_HOLD) begin
        addr_q <= addr_q + 1'b1;
      end
      // Hold address keeps pointing at the same register
    end else if (addr_load) begin
      addr_q <= pif_di;
    end
  end

  // Data byte capture
  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      byte_q[0] <= '0;
      byte_q[1] <= '0;
      byte_q[2] <= '0;
    end else if (byte_load) begin
      case (byte_lane)
        2'd0:    byte_q[0] <= pif_di;
        2'd1:    byte_q[1] <= pif_di;
        2'd2:    byte_q[2] <= pif_di;
        default: ; // Lane 3 is written to the FIFO directly
      endcase
    end
  end

  // Entry is valid in the cycle of the fourth data byte
  assign wff_entry = {addr_q, pif_di, byte_q[2], byte_q[1], byte_q[0]};

endmodule

// ==== pif_cmd_assembler.sv ====
// ==========================================================
// PIF command assembler
// Write sequencer turning PIF bytes into write-FIFO entries
// ==========================================================
module pif_cmd_assembler (
  input  logic                      fcb_sys_clk,
  input  logic                      fcb_sys_rst_n,
  input  logic                      pif_en,
  input  logic                      pif_vldi,
  input  pif_frame_pkg::pif_byte_t  pif_di,
  output logic                      wff_wr_en,
  output pif_frame_pkg::wff_entry_t wff_wr_data
);
  import pif_frame_pkg::*;
  import pif_fsm_pkg::*;

  wr_state_t  wr_state;
  wr_state_t  wr_state_ns;
  logic       addr_load;
  logic       byte_load;
  logic       addr_step;
  byte_lane_t byte_lane;
  pif_byte_t  addr_q;

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      wr_state <= WR_IDLE;
    end else begin
      wr_state <= wr_state_ns;
    end
  end

  always_comb begin
    wr_state_ns = WR_IDLE;  // Disable drops back to idle
    wff_wr_en   = 1'b0;
    addr_load   = 1'b0;
    byte_load   = 1'b0;
    addr_step   = 1'b0;
    byte_lane   = 2'd0;

    if (pif_en) begin
      wr_state_ns = wr_state;
      unique case (wr_state)
        WR_IDLE: wr_state_ns = WR_ADDR;
        WR_ADDR: begin
          if (pif_vldi) begin
            addr_load   = 1'b1;
            wr_state_ns = WR_ADDR_ONLY;
          end
        end
        WR_ADDR_ONLY: begin
          if (!addr_q[ADDR_DATA_BIT]) begin
            wff_wr_en   = 1'b1;     // Address-only entry
            wr_state_ns = WR_ADDR;
          end else if (pif_vldi) begin
            byte_load   = 1'b1;     // Data byte 0 right behind the address
            wr_state_ns = WR_DATA1;
          end else begin
            wr_state_ns = WR_DATA0;
          end
        end
        WR_DATA0: begin
          if (pif_vldi) begin
            byte_load   = 1'b1;
            wr_state_ns = WR_DATA1;
          end
        end
        WR_DATA1: begin
          byte_lane = 2'd1;
          if (pif_vldi) begin
            byte_load   = 1'b1;
            wr_state_ns = WR_DATA2;
          end
        end
        WR_DATA2: begin
          byte_lane = 2'd2;
          if (pif_vldi) begin
            byte_load   = 1'b1;
            wr_state_ns = WR_DATA3;
          end
        end
        WR_DATA3: begin
          if (pif_vldi) begin
            wff_wr_en   = 1'b1;     // Byte 3 taken from the bus
            wr_state_ns = WR_BURST;
          end
        end
        WR_BURST: begin
          if (pif_vldi) begin
            addr_step   = 1'b1;     // Next word of the burst
            byte_load   = 1'b1;
            wr_state_ns = WR_DATA1;
          end else begin
            wr_state_ns = WR_ADDR;
          end
        end
      endcase
    end
  end

  pif_frame_regs i_pif_frame_regs (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_di        (pif_di),
    .addr_load     (addr_load),
    .byte_load     (byte_load),
    .byte_lane     (byte_lane),
    .addr_step     (addr_step),
    .addr_q        (addr_q),
    .wff_entry     (wff_wr_data)
  );

endmodule

// ==== pif_rsp_serializer.sv ====
// ==========================================================
// PIF response serializer
// Sends read-FIFO words out as four bytes, LSB first
// ==========================================================
module pif_rsp_serializer (
  input  logic                     fcb_sys_clk,
  input  logic                     fcb_sys_rst_n,
  input  logic                     pif_en,
  input  logic                     crf_empty,
  input  pif_frame_pkg::pif_word_t crf_rd_data,
  output logic                     pif_vldo,
  output pif_frame_pkg::pif_byte_t pif_do,
  output logic                     crf_rd_en
);
  import pif_frame_pkg::*;
  import pif_fsm_pkg::*;

  rd_state_t  rd_state;
  rd_state_t  rd_state_ns;
  byte_lane_t rd_lane;

  always_ff @(posedge fcb_sys_clk or negedge fcb_sys_rst_n) begin
    if (!fcb_sys_rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      rd_state <= rd_state_ns;
    end
  end

  always_comb begin
    rd_state_ns = RD_IDLE;
    pif_vldo    = 1'b0;
    crf_rd_en   = 1'b0;
    rd_lane     = 2'd0;

    if (pif_en) begin
      rd_state_ns = rd_state;
      case (rd_state)
        RD_IDLE: rd_state_ns = RD_WAIT_WORD;
        RD_WAIT_WORD: begin
          if (!crf_empty) begin
            pif_vldo    = 1'b1;   // Byte 0 of the head word
            rd_state_ns = RD_BYTE1;
          end
        end
        RD_BYTE1: begin
          pif_vldo    = 1'b1;
          rd_lane     = 2'd1;
          rd_state_ns = RD_BYTE2;
        end
        RD_BYTE2: begin
          pif_vldo    = 1'b1;
          rd_lane     = 2'd2;
          rd_state_ns = RD_BYTE3;
        end
        RD_BYTE3: begin
          pif_vldo    = 1'b1;
          rd_lane     = 2'd3;
          crf_rd_en   = 1'b1;     // Pop with the last byte
          rd_state_ns = RD_WAIT_WORD;
        end
        default: rd_state_ns = RD_IDLE;
      endcase
    end
  end

  // Byte lane select on the head word
  assign pif_do = crf_rd_data[rd_lane*BYTE_W +: BYTE_W];

endmodule

// ==== pif_bridge.sv ====
// ==========================================================
// PIF bridge top
// Joins the PIF pins to the write and read FIFO ports
// ==========================================================
module pif_bridge (
  input  logic                      fcb_sys_clk,
  input  logic                      fcb_sys_rst_n,
  input  logic                      pif_en,       // Low forces both sequencers idle

  // PIF write side
  input  logic                      pif_vldi,
  input  pif_frame_pkg::pif_byte_t  pif_di,

  // PIF read side
  output logic                      pif_vldo,
  output pif_frame_pkg::pif_byte_t  pif_do,

  // Write FIFO
  output logic                      wff_wr_en,
  output pif_frame_pkg::wff_entry_t wff_wr_data,

  // Config read FIFO
  input  logic                      crf_empty,
  input  pif_frame_pkg::pif_word_t  crf_rd_data,  // Head word
  output logic                      crf_rd_en
);

  // Write path
  pif_cmd_assembler i_pif_cmd_assembler (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_en        (pif_en),
    .pif_vldi      (pif_vldi),
    .pif_di        (pif_di),
    .wff_wr_en     (wff_wr_en),
    .wff_wr_data   (wff_wr_data)
  );

  // Read path
  pif_rsp_serializer i_pif_rsp_serializer (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_en        (pif_en),
    .crf_empty     (crf_empty),
    .crf_rd_data   (crf_rd_data),
    .pif_vldo      (pif_vldo),
    .pif_do        (pif_do),
    .crf_rd_en     (crf_rd_en)
  );

endmodule

// ==== tb_pif_bridge.sv ====
// ==========================================================
// PIF bridge testbench
// Random write frames and read words checked against queue models
// ==========================================================
module tb_pif_bridge;
  timeunit 1ns;
  timeprecision 100ps;
  import pif_frame_pkg::*;

  localparam int RST_CYCLES = 16;
  localparam int WAIT_LIMIT = 200;
  localparam wff_entry_t ADDR_MASK = {8'hFF, 32'h0};  // Address-only entries

  logic       fcb_sys_clk;
  logic       fcb_sys_rst_n;
  logic       pif_en;
  logic       pif_vldi;
  pif_byte_t  pif_di;
  logic       pif_vldo;
  pif_byte_t  pif_do;
  logic       wff_wr_en;
  wff_entry_t wff_wr_data;
  logic       crf_empty;
  pif_word_t  crf_rd_data;
  logic       crf_rd_en;

  logic [31:0] lfsr_state;
  int          mismatches;
  int          other_errs;
  int          pops;
  int          rd_lane;
  bit          quiet;       // No output may toggle
  bit          pop_seen;
  pif_word_t   head;
  wff_entry_t  exp_q[$];    // Expected write-FIFO entries
  wff_entry_t  exp_mask[$];
  pif_word_t   rd_q[$];     // Read FIFO contents
  pif_word_t   rd_exp[$];   // Words still due on pif_do

  pif_bridge i_pif_bridge (
    .fcb_sys_clk   (fcb_sys_clk),
    .fcb_sys_rst_n (fcb_sys_rst_n),
    .pif_en        (pif_en),
    .pif_vldi      (pif_vldi),
    .pif_di        (pif_di),
    .pif_vldo      (pif_vldo),
    .pif_do        (pif_do),
    .wff_wr_en     (wff_wr_en),
    .wff_wr_data   (wff_wr_data),
    .crf_empty     (crf_empty),
    .crf_rd_data   (crf_rd_data),
    .crf_rd_en     (crf_rd_en)
  );

  initial fcb_sys_clk = 1'b0;
  always #5 fcb_sys_clk = ~fcb_sys_clk;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      mismatches++;
    end
  endtask

  task automatic next_cycle();
    @(posedge fcb_sys_clk);
    #1;
  endtask

  task automatic idle(input int n);
    pif_vldi = 1'b0;
    repeat (n) next_cycle();
  endtask

  task automatic send_byte(input pif_byte_t b);
    pif_vldi = 1'b1;
    pif_di   = b;
    next_cycle();
    pif_vldi = 1'b0;
  endtask

  // Address byte and nwords words with no gap from byte 3 to the next byte 0
  task automatic send_burst(input pif_byte_t addr, input int nwords);
    pif_byte_t a;
    pif_word_t w;
    a = addr;
    send_byte(addr);
    for (int i = 0; i < nwords; i++) begin
      w = rand_bits(32);
      exp_q.push_back({a, w});
      exp_mask.push_back('1);
      for (int b = 0; b < WORD_BYTES; b++) begin
        if (b != 0 || i == 0) idle(rand_bits(1));
        send_byte(w[8*b +: 8]);
      end
      if (a != ADDR_HOLD) a = a + 1'b1;
    end
    idle(1);  // Burst window closes
  endtask

  task automatic wait_write_done();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("ERROR: timed out waiting for %0d write-FIFO entries", exp_q.size());
      other_errs++;
      exp_q.delete();
      exp_mask.delete();
    end
  endtask

  // All words sent on the PIF and popped from the read FIFO
  task automatic wait_read_done();
    int n;
    n = 0;
    while ((rd_exp.size() != 0 || rd_q.size() != 0) && n < WAIT_LIMIT) begin
      next_cycle();
      n++;
    end
    if (rd_exp.size() != 0 || rd_q.size() != 0) begin
      $display("ERROR: timed out with %0d read words not sent and %0d not popped",
               rd_exp.size(), rd_q.size());
      other_errs++;
    end
  endtask

  // Outputs sampled on the falling edge away from input changes
  always @(negedge fcb_sys_clk) begin
    if (quiet) begin
      check("wff_wr_en", wff_wr_en, 0);
      check("crf_rd_en", crf_rd_en, 0);
      check("pif_vldo", pif_vldo, 0);
    end
    if (wff_wr_en) begin
      if (exp_q.size() == 0) begin
        $display("ERROR: unexpected write-FIFO entry 0x%0h at %0t", wff_wr_data, $time);
        other_errs++;
      end else begin
        check("wff_wr_data", wff_wr_data & exp_mask[0], exp_q[0] & exp_mask[0]);
        exp_q.delete(0);
        exp_mask.delete(0);
      end
    end
    if (pif_vldo) begin
      if (rd_exp.size() == 0) begin
        $display("ERROR: pif_vldo high with no word pending at %0t", $time);
        other_errs++;
      end else begin
        head = rd_exp[0];
        check("pif_do", pif_do, head[8*rd_lane +: 8]);
        check("crf_rd_en", crf_rd_en, rd_lane == 3);
        if (rd_lane == 3) begin
          rd_exp.delete(0);
          rd_lane = 0;
        end else begin
          rd_lane++;
        end
      end
    end else begin
      check("crf_rd_en", crf_rd_en, 0);
    end
    pop_seen = crf_rd_en;
  end

  // Read FIFO model with the pop applied at the edge ending a crf_rd_en cycle
  always @(posedge fcb_sys_clk) begin
    #1;
    if (pop_seen) begin
      if (rd_q.size() == 0) begin
        $display("ERROR: read FIFO popped while empty at %0t", $time);
        other_errs++;
      end else begin
        rd_q.delete(0);
        pops++;
      end
    end
    crf_empty   = (rd_q.size() == 0);
    crf_rd_data = (rd_q.size() != 0) ? rd_q[0] : '0;
  end

  initial begin
    pif_byte_t addr;
    pif_word_t w;
    lfsr_state    = 32'h7276;
    mismatches    = 0;
    other_errs    = 0;
    pops          = 0;
    rd_lane       = 0;
    quiet         = 1'b1;
    pop_seen      = 1'b0;
    fcb_sys_rst_n = 1'b0;
    pif_en        = 1'b0;
    pif_vldi      = 1'b0;
    pif_di        = '0;
    crf_empty     = 1'b1;
    crf_rd_data   = '0;
    repeat (RST_CYCLES) @(posedge fcb_sys_clk);
    #1;
    fcb_sys_rst_n = 1'b1;

    repeat (8) send_byte(rand_bits(8));  // Ignored while disabled
    idle(2);
    quiet  = 1'b0;
    pif_en = 1'b1;
    idle(2);

    repeat (10) begin
      addr = 8'(rand_bits(7));
      exp_q.push_back({addr, 32'h0});
      exp_mask.push_back(ADDR_MASK);
      send_byte(addr);
      idle(1 + rand_bits(2));
    end
    wait_write_done();

    repeat (8) send_burst(8'h80 | 8'(rand_bits(7)), 1);
    wait_write_done();

    send_burst(8'h9E, 5);  // Runs into the hold address
    repeat (3) send_burst(8'h80 | 8'(rand_bits(7)), 2 + rand_bits(2));
    wait_write_done();

    @(negedge fcb_sys_clk);
    repeat (6) begin
      w = rand_bits(32);
      rd_q.push_back(w);
      rd_exp.push_back(w);
    end
    wait_read_done();
    check("read FIFO pops", pops, 6);

    // Drop the enable after two data bytes
    send_byte(8'hC3);
    send_byte(rand_bits(8));
    send_byte(rand_bits(8));
    pif_en = 1'b0;
    quiet  = 1'b1;
    idle(1);
    @(negedge fcb_sys_clk);
    repeat (2) begin  // Held back until the enable returns
      w = rand_bits(32);
      rd_q.push_back(w);
      rd_exp.push_back(w);
    end
    idle(3);
    send_byte(rand_bits(8));
    idle(2);
    pif_en = 1'b1;
    quiet  = 1'b0;
    idle(2);
    send_burst(8'h80 | 8'(rand_bits(7)), 1);
    wait_write_done();
    wait_read_done();
    check("read FIFO pops", pops, 8);
    idle(4);

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
pif_frame_pkg.sv
pif_fsm_pkg.sv
pif_frame_regs.sv
pif_cmd_assembler.sv
pif_rsp_serializer.sv
pif_bridge.sv
tb_pif_bridge.sv

// ==== Bender.yml ====
package:
  name: pif_bridge

sources:
  - pif_frame_pkg.sv
  - pif_fsm_pkg.sv
  - pif_frame_regs.sv
  - pif_cmd_assembler.sv
  - pif_rsp_serializer.sv
  - pif_bridge.sv
  - target: test
    files:
      - tb_pif_bridge.sv
